/* filelist.f */
+incdir+.
jtframe_mr_pkg.sv
jtframe_mr_dwnld.sv
jtframe_mr_ddrld.sv
jtframe_mr_fbwrite.sv
jtframe_mr_ddrmux.sv
jtframe_mr_top.sv
tb_ddr_model.sv
tb_jtframe_mister_properties.sv
tb_jtframe_mister.sv

/* jtframe_mr_consts.svh */
/* DDR geometry of the fast loader and the frame writer
   JTFRAME_MR_BURST must be a power of two, at least 2 */
`ifndef JTFRAME_MR_CONSTS_SVH
`define JTFRAME_MR_CONSTS_SVH

// Words per loader burst
`define JTFRAME_MR_BURST 4

// HPS index that selects a load from DDR
`define JTFRAME_MR_FASTIDX 8'h80

// Word address of the first byte of load data
`define JTFRAME_MR_LOADBASE 29'h0100000

// Frame buffer start, one word per pixel pair
`define JTFRAME_MR_FBBASE 29'h0200000

// Byte at offset n of the load region
`define JTFRAME_MR_LDBYTE(n) (8'((n) ^ ((n) >> 8)))

`endif

/* jtframe_mr_ddrld.sv */
/* Reads JTFRAME_MR_BURST words per request from JTFRAME_MR_LOADBASE on
   The last burst may fetch past the length; those bytes are not written */
`include "jtframe_mr_consts.svh"

module jtframe_mr_ddrld(
    input                               clk_rom,
    input                               rst_n,
    input                               ddrld_start,
    input                        [31:0] ddrld_len,
    // DDR port through the arbiter
    input                               ld_ddr_busy,
    input  jtframe_mr_pkg::ddr_data_t   DDRAM_DOUT,
    input                               DDRAM_DOUT_READY,
    output                              ld_rd,
    output jtframe_mr_pkg::ddr_addr_t   ld_addr_ddr,
    output jtframe_mr_pkg::burst_t      ld_burstcnt,
    // Byte stream to the download block
    output                              ld_wr,
    output jtframe_mr_pkg::ioctl_addr_t ld_addr,
    output                       [ 7:0] ld_dout,
    output                              ld_busy
);

localparam int WW = $clog2(`JTFRAME_MR_BURST);
localparam int BW = WW + 3;

jtframe_mr_pkg::ddrld_state_t st;
jtframe_mr_pkg::ddr_data_t    word_buf[`JTFRAME_MR_BURST];
logic [31:0]                  len_l;
logic [31:0]                  pos;
logic [WW-1:0]                wcnt;
logic [BW-1:0]                bcnt;

assign ld_rd       = st == jtframe_mr_pkg::LD_REQUEST;
assign ld_wr       = st == jtframe_mr_pkg::LD_DRAIN;
assign ld_busy     = st != jtframe_mr_pkg::LD_IDLE;
assign ld_burstcnt = jtframe_mr_pkg::burst_t'(`JTFRAME_MR_BURST);
assign ld_addr     = pos[26:0];
// Least significant byte of each word goes out first
assign ld_dout     = word_buf[bcnt[BW-1:3]][{bcnt[2:0], 3'd0} +: 8];

always_ff @(posedge clk_rom) begin
    if (!rst_n) begin
        st          <= jtframe_mr_pkg::LD_IDLE;
        pos         <= 0;
        wcnt        <= 0;
        bcnt        <= 0;
        ld_addr_ddr <= `JTFRAME_MR_LOADBASE;
    end else begin
        case (st)
            jtframe_mr_pkg::LD_IDLE: begin
                if (ddrld_start) begin
                    pos         <= 0;
                    ld_addr_ddr <= `JTFRAME_MR_LOADBASE;
                    if (ddrld_len != 0) begin
                        st <= jtframe_mr_pkg::LD_REQUEST;
                    end
                end
            end
            jtframe_mr_pkg::LD_REQUEST: begin
                // Request stays up until the arbiter takes it
                if (!ld_ddr_busy) begin
                    wcnt <= 0;
                    st   <= jtframe_mr_pkg::LD_RECEIVE;
                end
            end
            jtframe_mr_pkg::LD_RECEIVE: begin
                if (DDRAM_DOUT_READY) begin
                    wcnt <= wcnt + 1'd1;
                    if (&wcnt) begin
                        bcnt <= 0;
                        st   <= jtframe_mr_pkg::LD_DRAIN;
                    end
                end
            end
            jtframe_mr_pkg::LD_DRAIN: begin
                pos  <= pos + 1;
                bcnt <= bcnt + 1'd1;
                if (pos + 1 == len_l) begin
                    st <= jtframe_mr_pkg::LD_IDLE;
                end else if (&bcnt) begin
                    ld_addr_ddr <= ld_addr_ddr + jtframe_mr_pkg::ddr_addr_t'(`JTFRAME_MR_BURST);
                    st          <= jtframe_mr_pkg::LD_REQUEST;
                end
            end
            default: st <= jtframe_mr_pkg::LD_IDLE;
        endcase
    end
end

always_ff @(posedge clk_rom) begin
    if (st == jtframe_mr_pkg::LD_IDLE && ddrld_start) begin
        len_l <= ddrld_len;
    end
    if (st == jtframe_mr_pkg::LD_RECEIVE && DDRAM_DOUT_READY) begin
        word_buf[wcnt] <= DDRAM_DOUT;
    end
end

endmodule

/* jtframe_mr_ddrmux.sv */
/* Only the loader reads, so all returned data belongs to it
   The port changes hands only with no request and no read in flight */
module jtframe_mr_ddrmux(
    input                               clk_rom,
    input                               rst_n,
    input                               downloading,
    // Fast loader
    input                               ld_rd,
    input  jtframe_mr_pkg::ddr_addr_t   ld_addr_ddr,
    input  jtframe_mr_pkg::burst_t      ld_burstcnt,
    // Frame writer
    input                               fb_we,
    input  jtframe_mr_pkg::ddr_addr_t   fb_addr,
    input  jtframe_mr_pkg::ddr_data_t   fb_din,
    input  jtframe_mr_pkg::ddr_be_t     fb_be,
    input                               DDRAM_BUSY,
    input                               DDRAM_DOUT_READY,
    output                              ld_ddr_busy,
    output                              fb_ddr_busy,
    output                              DDRAM_RD,
    output                              DDRAM_WE,
    output jtframe_mr_pkg::ddr_addr_t   DDRAM_ADDR,
    output jtframe_mr_pkg::burst_t      DDRAM_BURSTCNT,
    output jtframe_mr_pkg::ddr_be_t     DDRAM_BE,
    output jtframe_mr_pkg::ddr_data_t   DDRAM_DIN
);

jtframe_mr_pkg::owner_t owner;
jtframe_mr_pkg::owner_t next_owner;
logic                   ld_own;
logic                   idle;
logic [8:0]             rd_pend;

assign ld_own         = owner == jtframe_mr_pkg::OWN_LD;
assign DDRAM_RD       = ld_own & ld_rd;
assign DDRAM_WE       = ~ld_own & fb_we;
assign DDRAM_ADDR     = ld_own ? ld_addr_ddr : fb_addr;
assign DDRAM_BURSTCNT = ld_own ? ld_burstcnt : 8'd1;
assign DDRAM_BE       = ld_own ? 8'hff : fb_be;
assign DDRAM_DIN      = ld_own ? 64'd0 : fb_din;
// A master without the port sees a busy slave
assign ld_ddr_busy    = ~ld_own | DDRAM_BUSY;
assign fb_ddr_busy    = ld_own | DDRAM_BUSY;
assign idle           = ~DDRAM_RD & ~DDRAM_WE & rd_pend == 0;

always_comb begin
    next_owner = owner;
    if (downloading && ld_rd) begin
        next_owner = jtframe_mr_pkg::OWN_LD;
    end else if (fb_we) begin
        next_owner = jtframe_mr_pkg::OWN_FB;
    end else if (ld_rd) begin
        next_owner = jtframe_mr_pkg::OWN_LD;
    end
end

always_ff @(posedge clk_rom) begin
    if (!rst_n) begin
        owner   <= jtframe_mr_pkg::OWN_LD;
        rd_pend <= 0;
    end else begin
        if (idle) begin
            owner <= next_owner;
        end
        // Words still to come back from accepted reads
        if (DDRAM_RD && !DDRAM_BUSY) begin
            rd_pend <= rd_pend + 9'(DDRAM_BURSTCNT) - 9'(DDRAM_DOUT_READY);
        end else if (DDRAM_DOUT_READY) begin
            rd_pend <= rd_pend - 9'd1;
        end
    end
end

endmodule

/* jtframe_mr_dwnld.sv */
/* A fast load sends only a 4-byte little endian length over the HPS
   The data itself comes from DDR once hps_download falls */
`include "jtframe_mr_consts.svh"

module jtframe_mr_dwnld(
    input                               clk_rom,
    input                               rst_n,
    input                               hps_download,
    input                        [ 7:0] hps_index,
    input                               hps_wr,
    input  jtframe_mr_pkg::ioctl_addr_t hps_addr,
    input                        [ 7:0] hps_dout,
    // Bytes read back by the DDR loader
    input                               ld_wr,
    input  jtframe_mr_pkg::ioctl_addr_t ld_addr,
    input                        [ 7:0] ld_dout,
    input                               ld_busy,
    output                              hps_wait,
    output logic                        ioctl_rom_wr,
    output jtframe_mr_pkg::ioctl_addr_t ioctl_addr,
    output logic                 [ 7:0] ioctl_dout,
    output logic                        downloading,
    output                              ddrld_start,
    output logic                 [31:0] ddrld_len
);

logic fast;
logic fast_l;
logic dl_l;

assign fast        = hps_index == `JTFRAME_MR_FASTIDX;
// End of a fast-load header
assign ddrld_start = dl_l & ~hps_download & fast_l;
// HPS holds off while the loader owns the ioctl bus
assign hps_wait    = ld_busy;

always_ff @(posedge clk_rom) begin
    if (!rst_n) begin
        dl_l         <= 0;
        fast_l       <= 0;
        ioctl_rom_wr <= 0;
        downloading  <= 0;
    end else begin
        dl_l <= hps_download;
        if (hps_download) begin
            fast_l <= fast;
        end
        ioctl_rom_wr <= (hps_wr & ~fast) | ld_wr;
        // Covers the gap until the loader reports busy
        downloading  <= hps_download | ddrld_start | ld_busy;
    end
end

always_ff @(posedge clk_rom) begin
    if (ld_wr) begin
        ioctl_addr <= ld_addr;
        ioctl_dout <= ld_dout;
    end else if (hps_wr) begin
        ioctl_addr <= hps_addr;
        ioctl_dout <= hps_dout;
    end
    if (hps_download && !dl_l) begin
        ddrld_len <= 0;
    end else if (hps_wr && fast && hps_addr < 4) begin
        ddrld_len[{hps_addr[1:0], 3'd0} +: 8] <= hps_dout;
    end
end

endmodule

/* jtframe_mr_fbwrite.sv */
/* Two pixels per DDR word, first pixel in the low 32-bit lane
   Pixels arriving with the FIFO full are dropped */
`include "jtframe_mr_consts.svh"

module jtframe_mr_fbwrite(
    input                               clk_rom,
    input                               rst_n,
    input                               scan2x_cen,
    input                               scan2x_de,
    input                               scan2x_vs,
    input  jtframe_mr_pkg::pixel_t      scan2x_pxl,
    input                               fb_ddr_busy,
    output                              fb_we,
    output jtframe_mr_pkg::ddr_addr_t   fb_addr,
    output jtframe_mr_pkg::ddr_data_t   fb_din,
    output jtframe_mr_pkg::ddr_be_t     fb_be
);

jtframe_mr_pkg::fbw_state_t st;
jtframe_mr_pkg::pixel_t     fifo_mem[4];
jtframe_mr_pkg::ddr_addr_t  next_addr;
logic [2:0]                 wr_ptr;
logic [2:0]                 rd_ptr;
logic [2:0]                 fill;
logic                       vs_l;
logic                       vs_rise;
logic                       push;
logic                       launch;

// Pointers carry one extra bit so that full and empty differ
assign fill    = wr_ptr - rd_ptr;
assign vs_rise = scan2x_vs & ~vs_l;
assign push    = scan2x_cen & scan2x_de & ~fill[2];
// No new word in the cycle the frame restarts
assign launch  = st == jtframe_mr_pkg::FBW_IDLE && fill >= 3'd2 && !vs_rise;
assign fb_we   = st == jtframe_mr_pkg::FBW_WRITE;
assign fb_be   = '1;

always_ff @(posedge clk_rom) begin
    if (!rst_n) begin
        st        <= jtframe_mr_pkg::FBW_IDLE;
        wr_ptr    <= 0;
        rd_ptr    <= 0;
        vs_l      <= 0;
        next_addr <= `JTFRAME_MR_FBBASE;
    end else begin
        vs_l <= scan2x_vs;
        if (push) begin
            wr_ptr <= wr_ptr + 3'd1;
        end
        // New frame drops a half-filled pair
        if (vs_rise) begin
            rd_ptr    <= wr_ptr;
            next_addr <= `JTFRAME_MR_FBBASE;
        end else if (launch) begin
            rd_ptr    <= rd_ptr + 3'd2;
            next_addr <= next_addr + 1'd1;
        end
        case (st)
            jtframe_mr_pkg::FBW_IDLE: begin
                if (launch) begin
                    st <= jtframe_mr_pkg::FBW_WRITE;
                end
            end
            jtframe_mr_pkg::FBW_WRITE: begin
                if (!fb_ddr_busy) begin
                    st <= jtframe_mr_pkg::FBW_IDLE;
                end
            end
            default: st <= jtframe_mr_pkg::FBW_IDLE;
        endcase
    end
end

always_ff @(posedge clk_rom) begin
    if (push) begin
        fifo_mem[wr_ptr[1:0]] <= scan2x_pxl;
    end
    if (launch) begin
        fb_addr <= next_addr;
        fb_din  <= {8'd0, fifo_mem[rd_ptr[1:0] + 2'd1], 8'd0, fifo_mem[rd_ptr[1:0]]};
    end
end

endmodule

/* jtframe_mr_pkg.sv */
/* Types shared by the DDR side of the MiSTer wrapper
   Widths follow the fixed MiSTer DDR3 port */
package jtframe_mr_pkg;

    // DDR port, 64-bit words
    typedef logic [28:0] ddr_addr_t;
    typedef logic [63:0] ddr_data_t;
    typedef logic [ 7:0] ddr_be_t;
    typedef logic [ 7:0] burst_t;

    // Byte address of the download stream
    typedef logic [26:0] ioctl_addr_t;

    // 8 bits per colour
    typedef logic [23:0] pixel_t;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_REQUEST,
        LD_RECEIVE,
        LD_DRAIN
    } ddrld_state_t;

    typedef enum logic {
        FBW_IDLE,
        FBW_WRITE
    } fbw_state_t;

    typedef enum logic {
        OWN_LD,
        OWN_FB
    } owner_t;

endpackage

/* jtframe_mr_top.sv */
/* DDR side of the MiSTer wrapper, all on clk_rom
   Loader and frame writer share one DDR port */
module jtframe_mr_top(
    input                               clk_rom,
    input                               rst_n,
    // HPS byte stream
    input                               hps_download,
    input                        [ 7:0] hps_index,
    input                               hps_wr,
    input  jtframe_mr_pkg::ioctl_addr_t hps_addr,
    input                        [ 7:0] hps_dout,
    output                              hps_wait,
    // ROM programming
    output                              ioctl_rom_wr,
    output jtframe_mr_pkg::ioctl_addr_t ioctl_addr,
    output                       [ 7:0] ioctl_dout,
    output                              downloading,
    // Scan doubler pixels
    input                               scan2x_cen,
    input                               scan2x_de,
    input                               scan2x_vs,
    input  jtframe_mr_pkg::pixel_t      scan2x_pxl,
    // DDR3
    input                               DDRAM_BUSY,
    input  jtframe_mr_pkg::ddr_data_t   DDRAM_DOUT,
    input                               DDRAM_DOUT_READY,
    output                              DDRAM_RD,
    output                              DDRAM_WE,
    output jtframe_mr_pkg::ddr_addr_t   DDRAM_ADDR,
    output jtframe_mr_pkg::burst_t      DDRAM_BURSTCNT,
    output jtframe_mr_pkg::ddr_be_t     DDRAM_BE,
    output jtframe_mr_pkg::ddr_data_t   DDRAM_DIN
);

logic                        ddrld_start;
logic                 [31:0] ddrld_len;
logic                        ld_wr;
logic                        ld_busy;
jtframe_mr_pkg::ioctl_addr_t ld_addr;
logic                 [ 7:0] ld_dout;
logic                        ld_rd;
logic                        ld_ddr_busy;
jtframe_mr_pkg::ddr_addr_t   ld_addr_ddr;
jtframe_mr_pkg::burst_t      ld_burstcnt;
logic                        fb_we;
logic                        fb_ddr_busy;
jtframe_mr_pkg::ddr_addr_t   fb_addr;
jtframe_mr_pkg::ddr_data_t   fb_din;
jtframe_mr_pkg::ddr_be_t     fb_be;

jtframe_mr_dwnld u_dwnld(
    .clk_rom        ( clk_rom         ),
    .rst_n          ( rst_n           ),
    .hps_download   ( hps_download    ),
    .hps_index      ( hps_index       ),
    .hps_wr         ( hps_wr          ),
    .hps_addr       ( hps_addr        ),
    .hps_dout       ( hps_dout        ),
    .ld_wr          ( ld_wr           ),
    .ld_addr        ( ld_addr         ),
    .ld_dout        ( ld_dout         ),
    .ld_busy        ( ld_busy         ),
    .hps_wait       ( hps_wait        ),
    .ioctl_rom_wr   ( ioctl_rom_wr    ),
    .ioctl_addr     ( ioctl_addr      ),
    .ioctl_dout     ( ioctl_dout      ),
    .downloading    ( downloading     ),
    .ddrld_start    ( ddrld_start     ),
    .ddrld_len      ( ddrld_len       )
);

jtframe_mr_ddrld u_ddrld(
    .clk_rom        ( clk_rom         ),
    .rst_n          ( rst_n           ),
    .ddrld_start    ( ddrld_start     ),
    .ddrld_len      ( ddrld_len       ),
    .ld_ddr_busy    ( ld_ddr_busy     ),
    .DDRAM_DOUT     ( DDRAM_DOUT      ),
    .DDRAM_DOUT_READY( DDRAM_DOUT_READY ),
    .ld_rd          ( ld_rd           ),
    .ld_addr_ddr    ( ld_addr_ddr     ),
    .ld_burstcnt    ( ld_burstcnt     ),
    .ld_wr          ( ld_wr           ),
    .ld_addr        ( ld_addr         ),
    .ld_dout        ( ld_dout         ),
    .ld_busy        ( ld_busy         )
);

jtframe_mr_fbwrite u_fbwrite(
    .clk_rom        ( clk_rom         ),
    .rst_n          ( rst_n           ),
    .scan2x_cen     ( scan2x_cen      ),
    .scan2x_de      ( scan2x_de       ),
    .scan2x_vs      ( scan2x_vs       ),
    .scan2x_pxl     ( scan2x_pxl      ),
    .fb_ddr_busy    ( fb_ddr_busy     ),
    .fb_we          ( fb_we           ),
    .fb_addr        ( fb_addr         ),
    .fb_din         ( fb_din          ),
    .fb_be          ( fb_be           )
);

jtframe_mr_ddrmux u_ddrmux(
    .clk_rom        ( clk_rom         ),
    .rst_n          ( rst_n           ),
    .downloading    ( downloading     ),
    .ld_rd          ( ld_rd           ),
    .ld_addr_ddr    ( ld_addr_ddr     ),
    .ld_burstcnt    ( ld_burstcnt     ),
    .fb_we          ( fb_we           ),
    .fb_addr        ( fb_addr         ),
    .fb_din         ( fb_din          ),
    .fb_be          ( fb_be           ),
    .DDRAM_BUSY     ( DDRAM_BUSY      ),
    .DDRAM_DOUT_READY( DDRAM_DOUT_READY ),
    .ld_ddr_busy    ( ld_ddr_busy     ),
    .fb_ddr_busy    ( fb_ddr_busy     ),
    .DDRAM_RD       ( DDRAM_RD        ),
    .DDRAM_WE       ( DDRAM_WE        ),
    .DDRAM_ADDR     ( DDRAM_ADDR      ),
    .DDRAM_BURSTCNT ( DDRAM_BURSTCNT  ),
    .DDRAM_BE       ( DDRAM_BE        ),
    .DDRAM_DIN      ( DDRAM_DIN       )
);

endmodule

/* tb_ddr_model.sv */
/* DDR slave for simulation, one read burst in flight at a time
   Writes are accepted and dropped, read data follows the load byte rule */
`include "jtframe_mr_consts.svh"

module tb_ddr_model(
    input                             clk_rom,
    input                             rst_n,
    input                             DDRAM_RD,
    input  jtframe_mr_pkg::ddr_addr_t DDRAM_ADDR,
    input  jtframe_mr_pkg::burst_t    DDRAM_BURSTCNT,
    output                            DDRAM_BUSY,
    output jtframe_mr_pkg::ddr_data_t DDRAM_DOUT,
    output                            DDRAM_DOUT_READY
);
timeunit 1ns;
timeprecision 100ps;

logic                      busy  = 1'b0;
logic                      ready = 1'b0;
jtframe_mr_pkg::ddr_data_t dout  = '0;
jtframe_mr_pkg::ddr_addr_t rd_addr;
jtframe_mr_pkg::burst_t    rd_left;
logic               [ 1:0] delay;
logic               [31:0] lcg;

assign DDRAM_BUSY       = busy;
assign DDRAM_DOUT       = dout;
assign DDRAM_DOUT_READY = ready;

function automatic logic [31:0] next_random(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

// Eight load bytes of one word, lowest offset in the low byte
function automatic jtframe_mr_pkg::ddr_data_t load_word(input jtframe_mr_pkg::ddr_addr_t a);
    logic                [31:0] n;
    jtframe_mr_pkg::ddr_data_t  w;
    int                         k;
    for (k = 0; k < 8; k++) begin
        n = {3'd0, a - `JTFRAME_MR_LOADBASE};
        n = (n << 3) + k;
        w[k*8 +: 8] = `JTFRAME_MR_LDBYTE(n);
    end
    return w;
endfunction

always @(posedge clk_rom) begin
    if (!rst_n) begin
        lcg     <= 32'd26;
        busy    <= 1'b0;
        ready   <= 1'b0;
        rd_left <= 0;
        delay   <= 0;
    end else begin
        lcg   <= next_random(lcg);
        // Busy on about one cycle in four
        busy  <= lcg[29:28] == 2'd0;
        ready <= 1'b0;
        if (DDRAM_RD && !busy) begin
            rd_addr <= DDRAM_ADDR;
            rd_left <= DDRAM_BURSTCNT;
            delay   <= lcg[25:24];
        end else if (delay != 0) begin
            delay <= delay - 2'd1;
        end else if (rd_left != 0 && lcg[31]) begin
            dout    <= load_word(rd_addr);
            ready   <= 1'b1;
            rd_addr <= rd_addr + 1'd1;
            rd_left <= rd_left - 1'd1;
        end
    end
end

endmodule

/* tb_jtframe_mister.sv */
/* Inputs change on the falling edge of clk_rom
   All checking is done by the bound assertion module */
`include "jtframe_mr_consts.svh"

module tb_jtframe_mister;
timeunit 1ns;
timeprecision 100ps;

// Reset, 64 HPS bytes, 100 loader bytes in four bursts and two frames
// take about 500 cycles
localparam int TIMEOUT = 5000;

logic                        clk_rom = 1'b0;
logic                        rst_n;
logic                        hps_download;
logic                 [ 7:0] hps_index;
logic                        hps_wr;
jtframe_mr_pkg::ioctl_addr_t hps_addr;
logic                 [ 7:0] hps_dout;
logic                        scan2x_cen;
logic                        scan2x_de;
logic                        scan2x_vs;
jtframe_mr_pkg::pixel_t      scan2x_pxl;
wire                         hps_wait;
wire                         ioctl_rom_wr;
jtframe_mr_pkg::ioctl_addr_t ioctl_addr;
wire                  [ 7:0] ioctl_dout;
wire                         downloading;
wire                         DDRAM_BUSY;
jtframe_mr_pkg::ddr_data_t   DDRAM_DOUT;
wire                         DDRAM_DOUT_READY;
wire                         DDRAM_RD;
wire                         DDRAM_WE;
jtframe_mr_pkg::ddr_addr_t   DDRAM_ADDR;
jtframe_mr_pkg::burst_t      DDRAM_BURSTCNT;
jtframe_mr_pkg::ddr_be_t     DDRAM_BE;
jtframe_mr_pkg::ddr_data_t   DDRAM_DIN;
int                          cycles = 0;

always #50 clk_rom = ~clk_rom;

jtframe_mr_top dut0(.*);

tb_ddr_model ddr0(
    .clk_rom         ( clk_rom          ),
    .rst_n           ( rst_n            ),
    .DDRAM_RD        ( DDRAM_RD         ),
    .DDRAM_ADDR      ( DDRAM_ADDR       ),
    .DDRAM_BURSTCNT  ( DDRAM_BURSTCNT   ),
    .DDRAM_BUSY      ( DDRAM_BUSY       ),
    .DDRAM_DOUT      ( DDRAM_DOUT       ),
    .DDRAM_DOUT_READY( DDRAM_DOUT_READY )
);

bind jtframe_mr_top tb_jtframe_mister_properties u_props(.*);

task automatic print_counts(input int timeouts);
    $display("Assertion failures: %0d, timeouts: %0d", dut0.u_props.errors, timeouts);
endtask

// One HPS byte, held back while the loader owns the ioctl bus
task automatic send_byte(input jtframe_mr_pkg::ioctl_addr_t addr, input logic [7:0] data);
    @(negedge clk_rom);
    while (hps_wait) @(negedge clk_rom);
    hps_addr = addr;
    hps_dout = data;
    hps_wr   = 1'b1;
    @(negedge clk_rom);
    hps_wr   = 1'b0;
endtask

task automatic plain_download(input int len);
    int i;
    hps_index    = 8'h00;
    hps_download = 1'b1;
    for (i = 0; i < len; i++) begin
        send_byte(jtframe_mr_pkg::ioctl_addr_t'(i), 8'(i * 37 + 5));
    end
    @(negedge clk_rom);
    hps_download = 1'b0;
endtask

task automatic fast_load(input logic [31:0] len);
    int i;
    hps_index    = `JTFRAME_MR_FASTIDX;
    hps_download = 1'b1;
    for (i = 0; i < 4; i++) begin
        send_byte(jtframe_mr_pkg::ioctl_addr_t'(i), len[8*i +: 8]);
    end
    @(negedge clk_rom);
    hps_download = 1'b0;
    // Loader runs until downloading drops
    @(negedge clk_rom);
    while (downloading) @(negedge clk_rom);
endtask

// Pixels on every other cycle, then a quiet gap so the FIFO drains
task automatic stream_frame(input int npix);
    int i;
    @(negedge clk_rom);
    scan2x_vs = 1'b1;
    repeat (2) @(negedge clk_rom);
    scan2x_vs = 1'b0;
    scan2x_de = 1'b1;
    for (i = 0; i < npix; i++) begin
        scan2x_pxl = jtframe_mr_pkg::pixel_t'(i * 24'h010203 + 24'h102030);
        scan2x_cen = 1'b1;
        @(negedge clk_rom);
        scan2x_cen = 1'b0;
        @(negedge clk_rom);
    end
    scan2x_de = 1'b0;
    repeat (40) @(negedge clk_rom);
endtask

always @(posedge clk_rom) begin
    cycles++;
    if (cycles == TIMEOUT) begin
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
        print_counts(1);
        $display("Done: errors found");
        $finish;
    end
end

initial begin
    rst_n        = 1'b0;
    hps_download = 1'b0;
    hps_index    = 8'h00;
    hps_wr       = 1'b0;
    hps_addr     = '0;
    hps_dout     = 8'h00;
    scan2x_cen   = 1'b0;
    scan2x_de    = 1'b0;
    scan2x_vs    = 1'b0;
    scan2x_pxl   = '0;
    repeat (16) @(posedge clk_rom);
    @(negedge clk_rom);
    rst_n = 1'b1;
    plain_download(64);
    fork
        fast_load(100);
        stream_frame(48);
    join
    stream_frame(48);
    repeat (10) @(negedge clk_rom);
    print_counts(0);
    if (dut0.u_props.errors == 0) begin
        $display("Done: no errors");
    end else begin
        $display("Done: errors found");
    end
    $finish;
end

endmodule

/* tb_jtframe_mister_properties.sv */
/* Bound into jtframe_mr_top
   Frame address checks assume no write is pending when scan2x_vs rises */
`include "jtframe_mr_consts.svh"

module tb_jtframe_mister_properties(
    input                              clk_rom,
    input                              rst_n,
    input                              hps_download,
    input                       [ 7:0] hps_index,
    input                              hps_wr,
    input jtframe_mr_pkg::ioctl_addr_t hps_addr,
    input                       [ 7:0] hps_dout,
    input                              hps_wait,
    input                              ioctl_rom_wr,
    input jtframe_mr_pkg::ioctl_addr_t ioctl_addr,
    input                       [ 7:0] ioctl_dout,
    input                              downloading,
    input                              scan2x_vs,
    input                              DDRAM_BUSY,
    input                              DDRAM_DOUT_READY,
    input                              DDRAM_RD,
    input                              DDRAM_WE,
    input jtframe_mr_pkg::ddr_addr_t   DDRAM_ADDR,
    input jtframe_mr_pkg::burst_t      DDRAM_BURSTCNT,
    input jtframe_mr_pkg::ddr_be_t     DDRAM_BE,
    input jtframe_mr_pkg::ddr_data_t   DDRAM_DIN
);
timeunit 1ns;
timeprecision 100ps;

int                          errors  = 0;
logic                 [31:0] req_len = 0;
logic                 [31:0] loaded  = 0;
logic                 [31:0] rd_req  = 0;
logic                 [31:0] rd_back = 0;
jtframe_mr_pkg::ioctl_addr_t hps_addr_l;
logic                 [ 7:0] hps_dout_l;
jtframe_mr_pkg::ddr_addr_t   ddr_addr_l;
jtframe_mr_pkg::ddr_data_t   ddr_din_l;
jtframe_mr_pkg::ddr_addr_t   fb_exp;
logic                        rd_l;
logic                        we_l;
logic                        vs_l;
logic                        fast;

assign fast = hps_index == `JTFRAME_MR_FASTIDX;

always @(posedge clk_rom) begin
    hps_addr_l <= hps_addr;
    hps_dout_l <= hps_dout;
    ddr_addr_l <= DDRAM_ADDR;
    ddr_din_l  <= DDRAM_DIN;
    rd_l       <= DDRAM_RD;
    we_l       <= DDRAM_WE;
    vs_l       <= scan2x_vs;
    // Little endian length header
    if (hps_wr && fast && hps_addr < 4) begin
        req_len[{hps_addr[1:0], 3'd0} +: 8] <= hps_dout;
    end
    if (hps_download) begin
        loaded <= 0;
    end else if (ioctl_rom_wr && fast) begin
        loaded <= loaded + 1;
    end
    if (!rst_n || (scan2x_vs && !vs_l)) begin
        fb_exp <= `JTFRAME_MR_FBBASE;
    end else if (DDRAM_WE && !DDRAM_BUSY) begin
        fb_exp <= fb_exp + 1'd1;
    end
    // Read words asked for and returned so far
    if (!rst_n) begin
        rd_req  <= 0;
        rd_back <= 0;
    end else begin
        if (DDRAM_RD && !DDRAM_BUSY) begin
            rd_req <= rd_req + DDRAM_BURSTCNT;
        end
        if (DDRAM_DOUT_READY) begin
            rd_back <= rd_back + 1;
        end
    end
end

assert property (@(posedge clk_rom)
    !rst_n |=> !(ioctl_rom_wr | downloading | hps_wait | DDRAM_RD | DDRAM_WE))
else begin
    errors++;
    $error("CHECK FAILED {ioctl_rom_wr,downloading,hps_wait,DDRAM_RD,DDRAM_WE} got %h expected 00",
        $sampled({ioctl_rom_wr, downloading, hps_wait, DDRAM_RD, DDRAM_WE}));
end

assert property (@(posedge clk_rom) disable iff (!rst_n)
    hps_wr && !fast |=> ioctl_rom_wr && ioctl_addr == hps_addr_l)
else begin
    errors++;
    $error("CHECK FAILED ioctl_addr got %h expected %h, ioctl_rom_wr got %h",
        $sampled(ioctl_addr), $sampled(hps_addr_l), $sampled(ioctl_rom_wr));
end

assert property (@(posedge clk_rom) disable iff (!rst_n)
    hps_wr && !fast |=> ioctl_dout == hps_dout_l)
else begin
    errors++;
    $error("CHECK FAILED ioctl_dout got %h expected %h",
        $sampled(ioctl_dout), $sampled(hps_dout_l));
end

// Fast-load byte at offset n is n[7:0] ^ n[15:8]
assert property (@(posedge clk_rom) disable iff (!rst_n)
    ioctl_rom_wr && fast |-> ioctl_dout == (ioctl_addr[7:0] ^ ioctl_addr[15:8]))
else begin
    errors++;
    $error("CHECK FAILED ioctl_dout got %h expected %h at ioctl_addr %h", $sampled(ioctl_dout),
        $sampled(ioctl_addr[7:0] ^ ioctl_addr[15:8]), $sampled(ioctl_addr));
end

assert property (@(posedge clk_rom) disable iff (!rst_n)
    ioctl_rom_wr && fast |-> ioctl_addr < req_len)
else begin
    errors++;
    $error("CHECK FAILED ioctl_addr got %h limit %h", $sampled(ioctl_addr), $sampled(req_len));
end

assert property (@(posedge clk_rom) disable iff (!rst_n)
    $fell(downloading) && fast |-> loaded == req_len)
else begin
    errors++;
    $error("CHECK FAILED loaded bytes got %h expected %h", $sampled(loaded), $sampled(req_len));
end

assert property (@(posedge clk_rom) disable iff (!rst_n)
    DDRAM_RD |-> DDRAM_BURSTCNT == `JTFRAME_MR_BURST)
else begin
    errors++;
    $error("CHECK FAILED DDRAM_BURSTCNT got %h expected %h", $sampled(DDRAM_BURSTCNT),
        8'(`JTFRAME_MR_BURST));
end

// Request held while the slave is busy
assert property (@(posedge clk_rom) disable iff (!rst_n)
    DDRAM_BUSY && (DDRAM_RD || DDRAM_WE) |=>
        DDRAM_RD == rd_l && DDRAM_WE == we_l && DDRAM_ADDR == ddr_addr_l)
else begin
    errors++;
    $error("CHECK FAILED DDRAM_ADDR got %h expected %h, {DDRAM_RD,DDRAM_WE} got %h expected %h",
        $sampled(DDRAM_ADDR), $sampled(ddr_addr_l), $sampled({DDRAM_RD, DDRAM_WE}),
        $sampled({rd_l, we_l}));
end

assert property (@(posedge clk_rom) disable iff (!rst_n)
    DDRAM_BUSY && (DDRAM_RD || DDRAM_WE) |=> DDRAM_DIN == ddr_din_l)
else begin
    errors++;
    $error("CHECK FAILED DDRAM_DIN got %h expected %h",
        $sampled(DDRAM_DIN), $sampled(ddr_din_l));
end

assert property (@(posedge clk_rom) disable iff (!rst_n)
    DDRAM_WE |-> DDRAM_ADDR == fb_exp && DDRAM_BE == 8'hff)
else begin
    errors++;
    $error("CHECK FAILED frame DDRAM_ADDR got %h expected %h, DDRAM_BE got %h expected ff",
        $sampled(DDRAM_ADDR), $sampled(fb_exp), $sampled(DDRAM_BE));
end

// A write waits until every word of the last read burst is back
assert property (@(posedge clk_rom) disable iff (!rst_n)
    DDRAM_WE |-> !DDRAM_RD && rd_req == rd_back)
else begin
    errors++;
    $error("CHECK FAILED {DDRAM_RD,DDRAM_WE} got %h, read words due %h returned %h",
        $sampled({DDRAM_RD, DDRAM_WE}), $sampled(rd_req), $sampled(rd_back));
end

endmodule
